//--- Bender.yml
package:
  name: id_stage

sources:
  - common/id_pkg.sv
  - src/compressed_expander.sv
  - decode/instr_decoder.sv
  - src/issue_register.sv
  - src/id_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_id_stage.sv

//--- common/id_pkg.sv
// Decode types, opcodes and exception causes shared by the decode stage RTL and its testbench
package id_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] instr_t;
  typedef logic [4:0]      reg_idx_t;

  // ------------------------------
  // RV32I major opcodes
  // ------------------------------
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_JAL    = 7'b1101111
  } opcode_e;

  // ------------------------------
  // Functional units and operations
  // ------------------------------
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_LOAD   = 3'd2,
    FU_STORE  = 3'd3,
    FU_BRANCH = 3'd4,
    FU_JUMP   = 3'd5
  } fu_e;

  // ADD is the zero encoding, so a cleared entry reads as ADD
  typedef enum logic [4:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    EQ, NE, LT, GE, LTU, GEU,
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    LUI, AUIPC, JAL, JALR
  } fu_op_e;

  // ------------------------------
  // Exceptions
  // ------------------------------
  typedef enum logic [3:0] {
    CAUSE_NONE         = 4'd0,
    INSTR_ACCESS_FAULT = 4'd1,
    ILLEGAL_INSTR      = 4'd2
  } cause_e;

  typedef struct packed {
    logic              valid;
    cause_e            cause;
    logic [XLEN-1:0]   tval;
  } exception_t;

  // One decoded instruction as handed to issue
  typedef struct packed {
    logic [XLEN-1:0] pc;
    fu_e             fu;
    fu_op_e          op;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    reg_idx_t        rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            is_compressed;
    exception_t      ex;
  } sb_entry_t;

endpackage

//--- decode/instr_decoder.sv
// Combinational RV32I decoder, builds the scoreboard entry and control-flow flag for issue
`timescale 1ns/10ps

module instr_decoder (
  input  id_pkg::instr_t    pc_i,
  input  id_pkg::instr_t    instr_i,
  input  id_pkg::instr_t    orig_instr_i,
  input  logic              is_compressed_i,
  input  logic              illegal_i,
  input  logic              fetch_ex_i,
  output id_pkg::sb_entry_t entry_o,
  output logic              is_ctrl_flow_o
);

  logic [2:0]     funct3;
  logic [6:0]     funct7;
  logic           legal;
  logic           ctrl_flow;
  logic           use_rs1;
  logic           use_rs2;
  logic           use_rd;
  logic           use_imm;
  id_pkg::fu_e    fu;
  id_pkg::fu_op_e op;
  id_pkg::instr_t imm;
  id_pkg::instr_t imm_i;
  id_pkg::instr_t imm_s;
  id_pkg::instr_t imm_b;
  id_pkg::instr_t imm_u;
  id_pkg::instr_t imm_j;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared ALU operation table of OP and OP_IMM
  function automatic id_pkg::fu_op_e alu_op(input logic [2:0] f3, input logic alt);
    id_pkg::fu_op_e res;
    case (f3)
      3'b000:  res = alt ? id_pkg::SUB : id_pkg::ADD;
      3'b001:  res = id_pkg::SLL;
      3'b010:  res = id_pkg::SLT;
      3'b011:  res = id_pkg::SLTU;
      3'b100:  res = id_pkg::XOR;
      3'b101:  res = alt ? id_pkg::SRA : id_pkg::SRL;
      3'b110:  res = id_pkg::OR;
      default: res = id_pkg::AND;
    endcase
    return res;
  endfunction

  // ------------------------------
  // Immediate extraction
  // ------------------------------
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'h000};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21],
                  1'b0};

  // ------------------------------
  // Opcode classification
  // ------------------------------
  always_comb begin
    fu        = id_pkg::FU_NONE;
    op        = id_pkg::ADD;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    use_rd    = 1'b0;
    use_imm   = 1'b0;
    imm       = '0;
    ctrl_flow = 1'b0;
    legal     = 1'b1;
    case (instr_i[6:0])
      id_pkg::OPCODE_LUI, id_pkg::OPCODE_AUIPC: begin
        fu      = id_pkg::FU_ALU;
        op      = instr_i[5] ? id_pkg::LUI : id_pkg::AUIPC;
        use_rd  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
      end
      id_pkg::OPCODE_JAL: begin
        fu        = id_pkg::FU_JUMP;
        op        = id_pkg::JAL;
        use_rd    = 1'b1;
        imm       = imm_j;
        ctrl_flow = 1'b1;
      end
      id_pkg::OPCODE_JALR: begin
        fu        = id_pkg::FU_JUMP;
        op        = id_pkg::JALR;
        use_rs1   = 1'b1;
        use_rd    = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_i;
        ctrl_flow = 1'b1;
        legal     = (funct3 == 3'b000);
      end
      id_pkg::OPCODE_BRANCH: begin
        fu        = id_pkg::FU_BRANCH;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        imm       = imm_b;
        ctrl_flow = 1'b1;
        case (funct3)
          3'b000:  op = id_pkg::EQ;
          3'b001:  op = id_pkg::NE;
          3'b100:  op = id_pkg::LT;
          3'b101:  op = id_pkg::GE;
          3'b110:  op = id_pkg::LTU;
          3'b111:  op = id_pkg::GEU;
          default: legal = 1'b0;
        endcase
      end
      id_pkg::OPCODE_LOAD: begin
        fu      = id_pkg::FU_LOAD;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_i;
        case (funct3)
          3'b000:  op = id_pkg::LB;
          3'b001:  op = id_pkg::LH;
          3'b010:  op = id_pkg::LW;
          3'b100:  op = id_pkg::LBU;
          3'b101:  op = id_pkg::LHU;
          default: legal = 1'b0;
        endcase
      end
      id_pkg::OPCODE_STORE: begin
        fu      = id_pkg::FU_STORE;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_imm = 1'b1;
        imm     = imm_s;
        case (funct3)
          3'b000:  op = id_pkg::SB;
          3'b001:  op = id_pkg::SH;
          3'b010:  op = id_pkg::SW;
          default: legal = 1'b0;
        endcase
      end
      id_pkg::OPCODE_OP_IMM: begin
        fu      = id_pkg::FU_ALU;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        use_imm = 1'b1;
        imm     = imm_i;
        // Bit 30 only selects SRAI, for the other ops it is immediate
        op      = alu_op(funct3, (funct3 == 3'b101) && instr_i[30]);
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      end
      id_pkg::OPCODE_OP: begin
        fu      = id_pkg::FU_ALU;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
        op      = alu_op(funct3, instr_i[30]);
        legal   = (funct7 == 7'b0000000) ||
                  ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      default: legal = 1'b0;
    endcase
  end

  // ------------------------------
  // Exception selection
  // ------------------------------
  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.is_compressed = is_compressed_i;
    is_ctrl_flow_o        = 1'b0;
    if (fetch_ex_i) begin
      // Fetch fault wins over anything found in the word
      entry_o.ex.valid = 1'b1;
      entry_o.ex.cause = id_pkg::INSTR_ACCESS_FAULT;
      entry_o.ex.tval  = pc_i;
    end else if (illegal_i || !legal) begin
      entry_o.ex.valid = 1'b1;
      entry_o.ex.cause = id_pkg::ILLEGAL_INSTR;
      entry_o.ex.tval  = orig_instr_i;
    end else begin
      entry_o.fu      = fu;
      entry_o.op      = op;
      entry_o.rs1     = use_rs1 ? instr_i[19:15] : 5'd0;
      entry_o.rs2     = use_rs2 ? instr_i[24:20] : 5'd0;
      entry_o.rd      = use_rd ? instr_i[11:7] : 5'd0;
      entry_o.imm     = imm;
      entry_o.use_imm = use_imm;
      is_ctrl_flow_o  = ctrl_flow;
    end
  end

endmodule

//--- list.f
+incdir+tests
common/id_pkg.sv
src/compressed_expander.sv
decode/instr_decoder.sv
src/issue_register.sv
src/id_stage.sv
tests/tb_id_stage.sv

//--- src/compressed_expander.sv
// Combinational RVC expander, turns a 16-bit compressed word into its RV32I form for the decoder
`timescale 1ns/10ps

module compressed_expander #(
  parameter bit RvcEn = 1'b1
) (
  input  id_pkg::instr_t instr_i,
  output id_pkg::instr_t instr_o,
  output id_pkg::instr_t orig_instr_o,
  output logic           is_compressed_o,
  output logic           illegal_o
);

  logic [15:0] c;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic        illegal_c;

  assign c    = instr_i[15:0];
  // Compressed register fields address x8..x15
  assign rdp  = {2'b01, c[4:2]};
  assign rs1p = {2'b01, c[9:7]};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);
  assign orig_instr_o    = is_compressed_o ? {16'h0000, c} : instr_i;
  assign illegal_o       = is_compressed_o && (!RvcEn || illegal_c);

  always_comb begin
    instr_o   = instr_i;
    illegal_c = 1'b0;
    if (is_compressed_o) begin
      instr_o = '0;
      case (c[1:0])
        // ------------------------------
        // Quadrant 0
        // ------------------------------
        2'b00: begin
          case (c[15:13])
            // C.ADDI4SPN, zero immediate is reserved and covers the all-zero word
            3'b000: begin
              instr_o = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000, rdp,
                         id_pkg::OPCODE_OP_IMM};
              illegal_c = (c[12:5] == 8'h00);
            end
            3'b010: instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rdp,
                               id_pkg::OPCODE_LOAD};
            3'b110: instr_o = {5'b0, c[5], c[12], rdp, rs1p, 3'b010, c[11:10], c[6], 2'b00,
                               id_pkg::OPCODE_STORE};
            default: illegal_c = 1'b1;
          endcase
        end
        // ------------------------------
        // Quadrant 1
        // ------------------------------
        2'b01: begin
          case (c[15:13])
            // C.ADDI and C.NOP
            3'b000: instr_o = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7],
                               id_pkg::OPCODE_OP_IMM};
            // C.LI
            3'b010: instr_o = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c[11:7],
                               id_pkg::OPCODE_OP_IMM};
            3'b011: begin
              if (c[11:7] == 5'd2) begin
                // C.ADDI16SP
                instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'd2, 3'b000, 5'd2,
                           id_pkg::OPCODE_OP_IMM};
              end else begin
                // C.LUI
                instr_o = {{15{c[12]}}, c[6:2], c[11:7], id_pkg::OPCODE_LUI};
              end
              illegal_c = ({c[12], c[6:2]} == 6'd0);
            end
            3'b100: begin
              case (c[11:10])
                2'b00: instr_o = {7'b0000000, c[6:2], rs1p, 3'b101, rs1p, id_pkg::OPCODE_OP_IMM};
                2'b01: instr_o = {7'b0100000, c[6:2], rs1p, 3'b101, rs1p, id_pkg::OPCODE_OP_IMM};
                2'b10: instr_o = {{6{c[12]}}, c[12], c[6:2], rs1p, 3'b111, rs1p,
                                  id_pkg::OPCODE_OP_IMM};
                default: begin
                  case (c[6:5])
                    2'b00: instr_o = {7'b0100000, rdp, rs1p, 3'b000, rs1p, id_pkg::OPCODE_OP};
                    2'b01: instr_o = {7'b0000000, rdp, rs1p, 3'b100, rs1p, id_pkg::OPCODE_OP};
                    2'b10: instr_o = {7'b0000000, rdp, rs1p, 3'b110, rs1p, id_pkg::OPCODE_OP};
                    default: instr_o = {7'b0000000, rdp, rs1p, 3'b111, rs1p, id_pkg::OPCODE_OP};
                  endcase
                end
              endcase
              // Shift amounts above 31 and the RV64 word ops do not exist here
              illegal_c = c[12] && (c[11:10] != 2'b10);
            end
            // C.J
            3'b101: instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                               {9{c[12]}}, 5'd0, id_pkg::OPCODE_JAL};
            // C.BEQZ and C.BNEZ, bit 13 selects the condition
            3'b110, 3'b111: instr_o = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 2'b00, c[13],
                                       c[11:10], c[4:3], c[12], id_pkg::OPCODE_BRANCH};
            default: illegal_c = 1'b1;
          endcase
        end
        // ------------------------------
        // Quadrant 2
        // ------------------------------
        2'b10: begin
          case (c[15:13])
            3'b000: begin
              instr_o = {7'b0000000, c[6:2], c[11:7], 3'b001, c[11:7], id_pkg::OPCODE_OP_IMM};
              illegal_c = c[12];
            end
            // C.LWSP, rd of x0 is reserved
            3'b010: begin
              instr_o = {4'b0000, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                         id_pkg::OPCODE_LOAD};
              illegal_c = (c[11:7] == 5'd0);
            end
            3'b100: begin
              if (c[6:2] == 5'd0) begin
                // C.JR and C.JALR, rs1 of x0 is reserved or C.EBREAK
                instr_o = {12'h000, c[11:7], 3'b000, 4'b0000, c[12], id_pkg::OPCODE_JALR};
                illegal_c = (c[11:7] == 5'd0);
              end else if (c[12]) begin
                instr_o = {7'b0000000, c[6:2], c[11:7], 3'b000, c[11:7], id_pkg::OPCODE_OP};
              end else begin
                instr_o = {7'b0000000, c[6:2], 5'd0, 3'b000, c[11:7], id_pkg::OPCODE_OP};
              end
            end
            3'b110: instr_o = {4'b0000, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00,
                               id_pkg::OPCODE_STORE};
            default: illegal_c = 1'b1;
          endcase
        end
        default: illegal_c = 1'b1;
      endcase
    end
  end

endmodule

//--- src/id_stage.sv
// Decode stage top, chains compressed expander, RV32I decoder and the issue register
`timescale 1ns/10ps

module id_stage #(
  parameter bit RvcEn = 1'b1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  // Fetch side
  input  logic              fetch_valid_i,
  output logic              fetch_ready_o,
  input  id_pkg::instr_t    fetch_addr_i,
  input  id_pkg::instr_t    fetch_instr_i,
  input  logic              fetch_ex_i,
  // Issue side
  output logic              issue_valid_o,
  output id_pkg::sb_entry_t issue_entry_o,
  output id_pkg::instr_t    orig_instr_o,
  output logic              is_ctrl_flow_o,
  output logic              is_compressed_o,
  input  logic              issue_ack_i
);

  id_pkg::instr_t    exp_instr;
  id_pkg::instr_t    exp_orig_instr;
  logic              exp_is_compressed;
  logic              exp_illegal;
  id_pkg::sb_entry_t dec_entry;
  logic              dec_ctrl_flow;

  // ------------------------------
  // Expand and decode
  // ------------------------------
  compressed_expander #(
    .RvcEn(RvcEn)
  ) compressed_expander_i (
    .instr_i        (fetch_instr_i),
    .instr_o        (exp_instr),
    .orig_instr_o   (exp_orig_instr),
    .is_compressed_o(exp_is_compressed),
    .illegal_o      (exp_illegal)
  );

  instr_decoder instr_decoder_i (
    .pc_i           (fetch_addr_i),
    .instr_i        (exp_instr),
    .orig_instr_i   (exp_orig_instr),
    .is_compressed_i(exp_is_compressed),
    .illegal_i      (exp_illegal),
    .fetch_ex_i     (fetch_ex_i),
    .entry_o        (dec_entry),
    .is_ctrl_flow_o (dec_ctrl_flow)
  );

  // ------------------------------
  // Decode to issue register
  // ------------------------------
  issue_register issue_register_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .entry_i       (dec_entry),
    .orig_instr_i  (exp_orig_instr),
    .is_ctrl_flow_i(dec_ctrl_flow),
    .issue_ack_i   (issue_ack_i),
    .issue_valid_o (issue_valid_o),
    .issue_entry_o (issue_entry_o),
    .orig_instr_o  (orig_instr_o),
    .is_ctrl_flow_o(is_ctrl_flow_o)
  );

  assign is_compressed_o = issue_entry_o.is_compressed;

endmodule

//--- src/issue_register.sv
// One-deep register between decode and issue with fetch ready, issue acknowledge and flush
`timescale 1ns/10ps

module issue_register (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              fetch_valid_i,
  output logic              fetch_ready_o,
  input  id_pkg::sb_entry_t entry_i,
  input  id_pkg::instr_t    orig_instr_i,
  input  logic              is_ctrl_flow_i,
  input  logic              issue_ack_i,
  output logic              issue_valid_o,
  output id_pkg::sb_entry_t issue_entry_o,
  output id_pkg::instr_t    orig_instr_o,
  output logic              is_ctrl_flow_o
);

  logic              valid_q;
  id_pkg::sb_entry_t entry_q;
  id_pkg::instr_t    orig_instr_q;
  logic              ctrl_flow_q;

  // Space now, or space after this edge because issue takes the current entry
  assign fetch_ready_o = fetch_valid_i && (!valid_q || issue_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // A word taken in the flush cycle is dropped
      valid_q <= 1'b0;
    end else if (fetch_ready_o) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_ready_o) begin
      entry_q      <= entry_i;
      orig_instr_q <= orig_instr_i;
      ctrl_flow_q  <= is_ctrl_flow_i;
    end
  end

  assign issue_valid_o  = valid_q;
  assign issue_entry_o  = entry_q;
  assign orig_instr_o   = orig_instr_q;
  assign is_ctrl_flow_o = ctrl_flow_q;

endmodule

//--- tests/id_ref.svh
// Expected decode results for the decode stage testbench, included inside the testbench module
`ifndef ID_REF_SVH
`define ID_REF_SVH

// ALU operation named by funct3 and the alternate bit
function automatic id_pkg::fu_op_e ref_alu(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? id_pkg::SUB : id_pkg::ADD;
    3'd1:    return id_pkg::SLL;
    3'd2:    return id_pkg::SLT;
    3'd3:    return id_pkg::SLTU;
    3'd4:    return id_pkg::XOR;
    3'd5:    return alt ? id_pkg::SRA : id_pkg::SRL;
    3'd6:    return id_pkg::OR;
    default: return id_pkg::AND;
  endcase
endfunction

// Expected entry for a 32-bit word, bad marks an encoding already known to be illegal
function automatic id_pkg::sb_entry_t ref_decode(input logic [31:0] pc, input logic [31:0] w,
                                                 input logic [31:0] orig, input logic comp,
                                                 input logic bad, input logic fault,
                                                 output logic cf);
  id_pkg::sb_entry_t e;
  logic              ok;
  logic [2:0]        f3;
  logic [6:0]        f7;
  e  = '0;
  ok = 1'b1;
  cf = 1'b0;
  f3 = w[14:12];
  f7 = w[31:25];
  case (w[6:0])
    7'b0110111, 7'b0010111: begin
      e.fu      = id_pkg::FU_ALU;
      e.op      = w[5] ? id_pkg::LUI : id_pkg::AUIPC;
      e.rd      = w[11:7];
      e.imm     = {w[31:12], 12'h000};
      e.use_imm = 1'b1;
    end
    7'b1101111: begin
      e.fu  = id_pkg::FU_JUMP;
      e.op  = id_pkg::JAL;
      e.rd  = w[11:7];
      e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      cf    = 1'b1;
    end
    7'b1100111: begin
      e.fu      = id_pkg::FU_JUMP;
      e.op      = id_pkg::JALR;
      e.rs1     = w[19:15];
      e.rd      = w[11:7];
      e.imm     = {{20{w[31]}}, w[31:20]};
      e.use_imm = 1'b1;
      cf        = 1'b1;
      ok        = (f3 == 3'd0);
    end
    7'b1100011: begin
      e.fu  = id_pkg::FU_BRANCH;
      e.rs1 = w[19:15];
      e.rs2 = w[24:20];
      e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      cf    = 1'b1;
      case (f3)
        3'd0:    e.op = id_pkg::EQ;
        3'd1:    e.op = id_pkg::NE;
        3'd4:    e.op = id_pkg::LT;
        3'd5:    e.op = id_pkg::GE;
        3'd6:    e.op = id_pkg::LTU;
        3'd7:    e.op = id_pkg::GEU;
        default: ok = 1'b0;
      endcase
    end
    7'b0000011: begin
      e.fu      = id_pkg::FU_LOAD;
      e.rs1     = w[19:15];
      e.rd      = w[11:7];
      e.imm     = {{20{w[31]}}, w[31:20]};
      e.use_imm = 1'b1;
      case (f3)
        3'd0:    e.op = id_pkg::LB;
        3'd1:    e.op = id_pkg::LH;
        3'd2:    e.op = id_pkg::LW;
        3'd4:    e.op = id_pkg::LBU;
        3'd5:    e.op = id_pkg::LHU;
        default: ok = 1'b0;
      endcase
    end
    7'b0100011: begin
      e.fu      = id_pkg::FU_STORE;
      e.rs1     = w[19:15];
      e.rs2     = w[24:20];
      e.imm     = {{20{w[31]}}, w[31:25], w[11:7]};
      e.use_imm = 1'b1;
      case (f3)
        3'd0:    e.op = id_pkg::SB;
        3'd1:    e.op = id_pkg::SH;
        3'd2:    e.op = id_pkg::SW;
        default: ok = 1'b0;
      endcase
    end
    7'b0010011: begin
      e.fu      = id_pkg::FU_ALU;
      e.rs1     = w[19:15];
      e.rd      = w[11:7];
      e.imm     = {{20{w[31]}}, w[31:20]};
      e.use_imm = 1'b1;
      e.op      = ref_alu(f3, (f3 == 3'd5) && (f7 == 7'h20));
      if (f3 == 3'd1) ok = (f7 == 7'h00);
      if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
    end
    7'b0110011: begin
      e.fu  = id_pkg::FU_ALU;
      e.rs1 = w[19:15];
      e.rs2 = w[24:20];
      e.rd  = w[11:7];
      e.op  = ref_alu(f3, f7 == 7'h20);
      ok    = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
    end
    default: ok = 1'b0;
  endcase
  if (fault || bad || !ok) begin
    e = '0;
    cf = 1'b0;
    e.ex.valid = 1'b1;
    e.ex.cause = fault ? id_pkg::INSTR_ACCESS_FAULT : id_pkg::ILLEGAL_INSTR;
    e.ex.tval  = fault ? pc : orig;
  end
  e.pc            = pc;
  e.is_compressed = comp;
  return e;
endfunction

// Compressed word and its 32-bit equivalent, from the RVC chapter of the ISA manual
localparam int NUM_COMP = 25;

function automatic logic [47:0] comp_pair(input int idx);
  case (idx)
    0:       return {16'h0001, 32'h00000013};
    1:       return {16'h0085, 32'h00108093};
    2:       return {16'h557D, 32'hFFF00513};
    3:       return {16'h852E, 32'h00B00533};
    4:       return {16'h952E, 32'h00B50533};
    5:       return {16'h8082, 32'h00008067};
    6:       return {16'h9282, 32'h000280E7};
    7:       return {16'h40C0, 32'h0044A403};
    8:       return {16'hC0C0, 32'h0084A223};
    9:       return {16'h0800, 32'h01010413};
    10:      return {16'h6505, 32'h00001537};
    11:      return {16'h6141, 32'h01010113};
    12:      return {16'hA011, 32'h0040006F};
    13:      return {16'hC401, 32'h00040463};
    14:      return {16'hE401, 32'h00041463};
    15:      return {16'h8005, 32'h00145413};
    16:      return {16'h8405, 32'h40145413};
    17:      return {16'h987D, 32'hFFF47413};
    18:      return {16'h8C05, 32'h40940433};
    19:      return {16'h8C25, 32'h00944433};
    20:      return {16'h8C45, 32'h00946433};
    21:      return {16'h8C65, 32'h00947433};
    22:      return {16'h050A, 32'h00251513};
    23:      return {16'h4512, 32'h00412503};
    default: return {16'hC22A, 32'h00A12223};
  endcase
endfunction

`endif

//--- tests/tb_id_stage.sv
// Testbench for the decode stage, drives fetch words and checks issued entries against a model
`timescale 1ns/10ps

module tb_id_stage;

  `include "id_ref.svh"

  localparam int NUM_RAND  = 200;
  localparam int NUM_EXC   = 9;
  localparam int NUM_BP    = 100;
  localparam int NUM_TPUT  = 40;
  localparam int NUM_FLUSH = 60;
  localparam int TOTAL     = NUM_RAND + NUM_COMP + NUM_EXC + NUM_BP + NUM_TPUT + NUM_FLUSH;
  localparam int MAX_CYCLES = 20 * TOTAL;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  logic              fetch_valid_i;
  logic              fetch_ready_o;
  logic [31:0]       fetch_addr_i;
  logic [31:0]       fetch_instr_i;
  logic              fetch_ex_i;
  logic              issue_valid_o;
  id_pkg::sb_entry_t issue_entry_o;
  logic [31:0]       orig_instr_o;
  logic              is_ctrl_flow_o;
  logic              is_compressed_o;
  logic              issue_ack_i;

  // Expected result of the word on the fetch port
  id_pkg::sb_entry_t cur_entry;
  logic [31:0]       cur_orig;
  logic              cur_cf;
  string             cur_name;

  id_pkg::sb_entry_t exp_entry_q[$];
  logic [31:0]       exp_orig_q[$];
  logic              exp_cf_q[$];
  string             exp_name_q[$];

  int   value_errors;
  int   proto_errors;
  int   cycles;
  int   ack_prob;
  logic accept_prev;
  logic flush_prev;

  id_stage #(
    .RvcEn(1'b1)
  ) id_stage_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_ex_i     (fetch_ex_i),
    .issue_valid_o  (issue_valid_o),
    .issue_entry_o  (issue_entry_o),
    .orig_instr_o   (orig_instr_o),
    .is_ctrl_flow_o (is_ctrl_flow_o),
    .is_compressed_o(is_compressed_o),
    .issue_ack_i    (issue_ack_i)
  );

  always #2 clk_i = ~clk_i;

  // ------------------------------
  // Issue side acknowledge
  // ------------------------------
  always @(posedge clk_i) begin
    #1;
    issue_ack_i = issue_valid_o && ($urandom_range(99) < ack_prob);
  end

  // ------------------------------
  // Compare process, sampled mid-cycle
  // ------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (accept_prev) begin
        assert (issue_valid_o) else begin
          $display("Issue valid did not rise one cycle after an accepted word");
          proto_errors++;
        end
      end
      if (flush_prev) begin
        assert (!issue_valid_o) else begin
          $display("Issue valid still high after a flush");
          proto_errors++;
        end
      end
      if (issue_valid_o && !issue_ack_i) begin
        assert (!fetch_ready_o) else begin
          $display("Fetch ready high while the issue register is full");
          proto_errors++;
        end
      end
      if (fetch_valid_i && (!issue_valid_o || issue_ack_i)) begin
        assert (fetch_ready_o) else begin
          $display("Fetch ready low although the issue register has space");
          proto_errors++;
        end
      end
      if (issue_valid_o && issue_ack_i) begin
        if (exp_entry_q.size() == 0) begin
          $display("An entry was issued with no word pending");
          proto_errors++;
        end else begin
          check_issue(exp_name_q.pop_front(), exp_entry_q.pop_front(), exp_orig_q.pop_front(),
                      exp_cf_q.pop_front());
        end
      end
      if (flush_i) begin
        exp_entry_q.delete();
        exp_orig_q.delete();
        exp_cf_q.delete();
        exp_name_q.delete();
      end else if (fetch_valid_i && fetch_ready_o) begin
        exp_entry_q.push_back(cur_entry);
        exp_orig_q.push_back(cur_orig);
        exp_cf_q.push_back(cur_cf);
        exp_name_q.push_back(cur_name);
      end
      accept_prev = fetch_valid_i && fetch_ready_o && !flush_i;
      flush_prev  = flush_i;
    end
  end

  task automatic check_issue(input string name, input id_pkg::sb_entry_t e,
                             input logic [31:0] orig, input logic cf);
    assert (issue_entry_o == e) else begin
      $display("ERROR %s entry: expected %h, actual %h", name, e, issue_entry_o);
      value_errors++;
    end
    assert (orig_instr_o == orig) else begin
      $display("ERROR %s orig_instr: expected %h, actual %h", name, orig, orig_instr_o);
      value_errors++;
    end
    assert ((is_ctrl_flow_o == cf) && (is_compressed_o == e.is_compressed)) else begin
      $display("ERROR %s flags: expected cf=%b c=%b, actual cf=%b c=%b", name, cf,
               e.is_compressed, is_ctrl_flow_o, is_compressed_o);
      value_errors++;
    end
  endtask

  // Drives one word until the stage takes it, flush only in the first cycle
  task automatic send_word(input string name, input logic [31:0] word, input logic [31:0] equiv,
                           input logic comp, input logic bad, input logic fault,
                           input logic do_flush);
    logic [31:0] pc;
    logic        took;
    logic        cf;
    pc        = $urandom & 32'hFFFF_FFFE;
    cur_orig  = comp ? {16'h0000, word[15:0]} : word;
    cur_entry = ref_decode(pc, equiv, cur_orig, comp, bad, fault, cf);
    cur_cf    = cf;
    cur_name  = name;
    fetch_valid_i = 1'b1;
    fetch_addr_i  = pc;
    fetch_instr_i = word;
    fetch_ex_i    = fault;
    flush_i       = do_flush;
    took          = 1'b0;
    while (!took) begin
      @(negedge clk_i);
      took = fetch_ready_o;
      @(posedge clk_i);
      #1;
      flush_i = 1'b0;
    end
    fetch_valid_i = 1'b0;
  endtask

  // Random word on a supported opcode, funct7 mostly legal
  function automatic logic [31:0] rand_rv32i();
    logic [31:0] w;
    logic [6:0]  ops [9];
    ops = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
            7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011};
    w = $urandom;
    w[6:0] = ops[$urandom_range(8)];
    if ((w[6:0] == 7'b0110011) || ((w[6:0] == 7'b0010011) && (w[13:12] == 2'b01))) begin
      if ($urandom_range(9) != 0) w[31:25] = w[30] ? 7'h20 : 7'h00;
    end
    return w;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    logic [47:0] pair;
    logic [31:0] w;
    void'($urandom(32'h69b85e20));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_addr_i = '0;
    fetch_instr_i = '0;
    fetch_ex_i = 1'b0;
    issue_ack_i = 1'b0;
    value_errors = 0;
    proto_errors = 0;
    cycles = 0;
    ack_prob = 50;
    accept_prev = 1'b0;
    flush_prev = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!issue_valid_o && !fetch_ready_o) else begin
      $display("Issue valid or fetch ready high after reset");
      proto_errors++;
    end
    @(posedge clk_i);
    #1;

    // A plain 32-bit word is its own equivalent
    for (int i = 0; i < NUM_RAND; i++) begin
      w = rand_rv32i();
      send_word("base_decode", w, w, 1'b0, 1'b0, 1'b0, 1'b0);
      idle($urandom_range(2));
    end
    for (int i = 0; i < NUM_COMP; i++) begin
      pair = comp_pair(i);
      w    = $urandom;
      send_word("compressed", {w[31:16], pair[47:32]}, pair[31:0], 1'b1, 1'b0, 1'b0, 1'b0);
    end

    // Illegal words, then fetch faults that outrank them
    send_word("exc_custom", 32'h0000000B, 32'h0000000B, 1'b0, 1'b0, 1'b0, 1'b0);
    send_word("exc_opcode", 32'h1234567F, 32'h1234567F, 1'b0, 1'b0, 1'b0, 1'b0);
    send_word("exc_system", 32'h00000073, 32'h00000073, 1'b0, 1'b0, 1'b0, 1'b0);
    send_word("exc_fence", 32'h0FF0000F, 32'h0FF0000F, 1'b0, 1'b0, 1'b0, 1'b0);
    send_word("exc_czero", 32'h00000000, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
    send_word("exc_cebreak", 32'h00009002, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
    send_word("exc_fault", 32'h00108093, 32'h00108093, 1'b0, 1'b0, 1'b1, 1'b0);
    send_word("exc_fault_c", 32'h00000085, 32'h00108093, 1'b1, 1'b0, 1'b1, 1'b0);
    send_word("exc_fault_ill", 32'h0FF0000F, 32'h0FF0000F, 1'b0, 1'b0, 1'b1, 1'b0);

    ack_prob = 15;
    for (int i = 0; i < NUM_BP; i++) begin
      w = rand_rv32i();
      send_word("backpressure", w, w, 1'b0, 1'b0, 1'b0, 1'b0);
    end

    // Words back to back with every entry acknowledged at once
    ack_prob = 100;
    idle(3);
    for (int i = 0; i < NUM_TPUT; i++) begin
      w = rand_rv32i();
      send_word("throughput", w, w, 1'b0, 1'b0, 1'b0, 1'b0);
    end

    ack_prob = 60;
    for (int i = 0; i < NUM_FLUSH; i++) begin
      w = rand_rv32i();
      send_word("flush", w, w, 1'b0, 1'b0, 1'b0, $urandom_range(4) == 0);
      idle($urandom_range(1));
    end

    ack_prob = 100;
    while (exp_entry_q.size() != 0) idle(1);
    idle(3);
    $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
    if ((value_errors == 0) && (proto_errors == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
